//--- flist.f
hw/img_pkg.sv
hw/mem_pkg.sv
hw/frame_ram.sv
hw/mem_arbiter.sv
hw/pixel_reader.sv
hw/line_buffer.sv
hw/window_buffer.sv
hw/max_filter.sv
hw/result_writer.sv
hw/dilate_top.sv
verif/dilate_sva.sv
verif/dilate_tb.sv

//--- hw/dilate_top.sv
`timescale 1ns/1ps

module dilate_top #(
  parameter int IMG_COLS = 16,
  parameter int IMG_ROWS = 12,
  parameter int WIN      = 3
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           start_i,
  output logic           done_o,
  input  logic           host_req_i,
  input  logic           host_we_i,
  input  mem_pkg::addr_t host_addr_i,
  input  mem_pkg::word_t host_wdata_i,
  output logic           host_gnt_o,
  output logic           host_rvalid_o,
  output mem_pkg::word_t host_rdata_o
);

  import img_pkg::*;
  import mem_pkg::*;

  logic                  wr_req;
  logic                  wr_gnt;
  addr_t                 wr_addr;
  pixel_t                wr_data;
  logic                  rd_req;
  logic                  rd_gnt;
  logic                  rd_valid;
  addr_t                 rd_addr;
  word_t                 rdata;
  logic                  ram_we;
  addr_t                 ram_addr;
  word_t                 ram_wdata;
  word_t                 ram_rdata;
  logic                  pix_valid;
  pixel_t                pix;
  logic                  col_valid;
  pixel_t [WIN-1:0]      col;
  logic                  win_valid;
  pixel_t [WIN*WIN-1:0]  win;
  logic                  res_valid;
  pixel_t                res;

  assign host_rdata_o = rdata;  // the shared read bus also serves the host.

  frame_ram frame_ram_i (
    .clk    (clk),
    .we_i   (ram_we),
    .addr_i (ram_addr),
    .wdata_i(ram_wdata),
    .rdata_o(ram_rdata)
  );

  mem_arbiter mem_arbiter_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_req_i     (wr_req),
    .wr_addr_i    (wr_addr),
    .wr_data_i    (wr_data),
    .wr_gnt_o     (wr_gnt),
    .rd_req_i     (rd_req),
    .rd_addr_i    (rd_addr),
    .rd_gnt_o     (rd_gnt),
    .rd_valid_o   (rd_valid),
    .host_req_i   (host_req_i),
    .host_we_i    (host_we_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_gnt_o   (host_gnt_o),
    .host_rvalid_o(host_rvalid_o),
    .ram_rdata_i  (ram_rdata),
    .rdata_o      (rdata),
    .ram_we_o     (ram_we),
    .ram_addr_o   (ram_addr),
    .ram_wdata_o  (ram_wdata)
  );

  pixel_reader #(
    .IMG_COLS(IMG_COLS),
    .IMG_ROWS(IMG_ROWS)
  ) pixel_reader_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (start_i),
    .gnt_i      (rd_gnt),
    .rvalid_i   (rd_valid),
    .rdata_i    (rdata),
    .req_o      (rd_req),
    .addr_o     (rd_addr),
    .pix_valid_o(pix_valid),
    .pix_o      (pix)
  );

  line_buffer #(
    .IMG_COLS(IMG_COLS),
    .WIN     (WIN)
  ) line_buffer_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .pix_valid_i(pix_valid),
    .pix_i      (pix),
    .col_valid_o(col_valid),
    .col_o      (col)
  );

  window_buffer #(
    .IMG_COLS(IMG_COLS),
    .IMG_ROWS(IMG_ROWS),
    .WIN     (WIN)
  ) window_buffer_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .shift_i    (col_valid),
    .col_i      (col),
    .win_valid_o(win_valid),
    .win_o      (win)
  );

  max_filter #(
    .WIN(WIN)
  ) max_filter_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .win_valid_i(win_valid),
    .win_i      (win),
    .res_valid_o(res_valid),
    .res_o      (res)
  );

  result_writer #(
    .IMG_COLS(IMG_COLS),
    .IMG_ROWS(IMG_ROWS),
    .WIN     (WIN)
  ) result_writer_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (start_i),
    .res_valid_i(res_valid),
    .res_i      (res),
    .gnt_i      (wr_gnt),
    .req_o      (wr_req),
    .addr_o     (wr_addr),
    .data_o     (wr_data),
    .done_o     (done_o)
  );

endmodule

//--- hw/frame_ram.sv
`timescale 1ns/1ps

module frame_ram (
  input  logic           clk,
  input  logic           we_i,
  input  mem_pkg::addr_t addr_i,
  input  mem_pkg::word_t wdata_i,
  output mem_pkg::word_t rdata_o
);

  import mem_pkg::*;

  word_t mem_q [MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
    rdata_o <= mem_q[addr_i];  // read data shows up one cycle after the address.
  end

endmodule

//--- hw/img_pkg.sv
package img_pkg;

  // grey level depth of one pixel.
  localparam int PIX_W = 8;

  typedef logic [PIX_W-1:0] pixel_t;

  // the source frame starts at word 0 and the results start here.
  localparam int unsigned RES_BASE = 256;

endpackage

//--- hw/line_buffer.sv
`timescale 1ns/1ps

module line_buffer #(
  parameter int IMG_COLS = 16,
  parameter int WIN      = 3
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      pix_valid_i,
  input  img_pkg::pixel_t           pix_i,
  output logic                      col_valid_o,
  output img_pkg::pixel_t [WIN-1:0] col_o
);

  import img_pkg::*;

  // line k delays the stream by k+1 rows.
  pixel_t [WIN-2:0][IMG_COLS-1:0] line_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      line_q <= '0;
    end else if (pix_valid_i) begin
      line_q[0] <= {line_q[0][IMG_COLS-2:0], pix_i};
      for (int k = 1; k < WIN - 1; k++) begin
        line_q[k] <= {line_q[k][IMG_COLS-2:0], line_q[k-1][IMG_COLS-1]};
      end
    end
  end

  always_comb begin
    col_o[WIN-1] = pix_i;  // the newest row comes straight from the input.
    for (int k = 0; k < WIN - 1; k++) begin
      col_o[WIN-2-k] = line_q[k][IMG_COLS-1];
    end
  end

  assign col_valid_o = pix_valid_i;

endmodule

//--- hw/max_filter.sv
`timescale 1ns/1ps

module max_filter #(
  parameter int WIN = 3
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          win_valid_i,
  input  img_pkg::pixel_t [WIN*WIN-1:0] win_i,
  output logic                          res_valid_o,
  output img_pkg::pixel_t               res_o
);

  import img_pkg::*;

  pixel_t max_c;
  pixel_t res_q;
  logic   res_valid_q;

  always_comb begin
    max_c = win_i[0];
    for (int i = 1; i < WIN * WIN; i++) begin
      if (win_i[i] > max_c) begin
        max_c = win_i[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (win_valid_i) begin
      res_q <= max_c;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= win_valid_i;
    end
  end

  assign res_valid_o = res_valid_q;
  assign res_o       = res_q;

endmodule

//--- hw/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           wr_req_i,
  input  mem_pkg::addr_t wr_addr_i,
  input  mem_pkg::word_t wr_data_i,
  output logic           wr_gnt_o,
  input  logic           rd_req_i,
  input  mem_pkg::addr_t rd_addr_i,
  output logic           rd_gnt_o,
  output logic           rd_valid_o,
  input  logic           host_req_i,
  input  logic           host_we_i,
  input  mem_pkg::addr_t host_addr_i,
  input  mem_pkg::word_t host_wdata_i,
  output logic           host_gnt_o,
  output logic           host_rvalid_o,
  input  mem_pkg::word_t ram_rdata_i,
  output mem_pkg::word_t rdata_o,
  output logic           ram_we_o,
  output mem_pkg::addr_t ram_addr_o,
  output mem_pkg::word_t ram_wdata_o
);

  logic rd_valid_q;
  logic host_rvalid_q;

  // the writer always wins, then the reader, then the host.
  assign wr_gnt_o   = wr_req_i;
  assign rd_gnt_o   = rd_req_i && !wr_req_i;
  assign host_gnt_o = host_req_i && !wr_req_i && !rd_req_i;

  always_comb begin
    ram_we_o    = 1'b0;
    ram_addr_o  = host_addr_i;
    ram_wdata_o = host_wdata_i;
    if (wr_gnt_o) begin
      ram_we_o    = 1'b1;
      ram_addr_o  = wr_addr_i;
      ram_wdata_o = wr_data_i;
    end else if (rd_gnt_o) begin
      ram_addr_o = rd_addr_i;
    end else if (host_gnt_o) begin
      ram_we_o = host_we_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid_q    <= 1'b0;
      host_rvalid_q <= 1'b0;
    end else begin
      rd_valid_q    <= rd_gnt_o;  // the reader only ever reads.
      host_rvalid_q <= host_gnt_o && !host_we_i;
    end
  end

  assign rd_valid_o    = rd_valid_q;
  assign host_rvalid_o = host_rvalid_q;
  assign rdata_o       = (rd_valid_q || host_rvalid_q) ? ram_rdata_i : '0;  // quiet when idle.

endmodule

//--- hw/mem_pkg.sv
package mem_pkg;

  localparam int ADDR_W = 9;
  localparam int DATA_W = 8;
  localparam int MEM_DEPTH = 1 << ADDR_W;  // 512 words.

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] word_t;

endpackage

//--- hw/pixel_reader.sv
`timescale 1ns/1ps

module pixel_reader #(
  parameter int IMG_COLS = 16,
  parameter int IMG_ROWS = 12
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start_i,
  input  logic            gnt_i,
  input  logic            rvalid_i,
  input  img_pkg::pixel_t rdata_i,
  output logic            req_o,
  output mem_pkg::addr_t  addr_o,
  output logic            pix_valid_o,
  output img_pkg::pixel_t pix_o
);

  import mem_pkg::*;

  localparam int NPIX = IMG_COLS * IMG_ROWS;

  logic  req_q;
  addr_t addr_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_q  <= 1'b0;
      addr_q <= '0;
    end else if (!req_q && start_i) begin
      req_q  <= 1'b1;
      addr_q <= '0;
    end else if (req_q && gnt_i) begin
      if (addr_q == addr_t'(NPIX - 1)) begin
        req_q <= 1'b0;  // last pixel of the frame has been issued.
      end else begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  assign req_o  = req_q;
  assign addr_o = addr_q;

  // returned words arrive in the same raster order as they were asked for.
  assign pix_valid_o = rvalid_i;
  assign pix_o       = rdata_i;

endmodule

//--- hw/result_writer.sv
`timescale 1ns/1ps

module result_writer #(
  parameter int IMG_COLS = 16,
  parameter int IMG_ROWS = 12,
  parameter int WIN      = 3
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start_i,
  input  logic            res_valid_i,
  input  img_pkg::pixel_t res_i,
  input  logic            gnt_i,
  output logic            req_o,
  output mem_pkg::addr_t  addr_o,
  output img_pkg::pixel_t data_o,
  output logic            done_o
);

  import img_pkg::*;
  import mem_pkg::*;

  localparam int NRES = (IMG_COLS - WIN + 1) * (IMG_ROWS - WIN + 1);

  logic  busy_q;
  logic  done_q;
  addr_t cnt_q;

  // top priority on the arbiter means a result is written in the cycle it appears.
  assign req_o  = res_valid_i;
  assign addr_o = addr_t'(RES_BASE) + cnt_q;
  assign data_o = res_i;
  assign done_o = done_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start_i && !busy_q) begin
      busy_q <= 1'b1;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (req_o && gnt_i) begin
      if (cnt_q == addr_t'(NRES - 1)) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;  // held until the next start.
        cnt_q  <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

//--- hw/window_buffer.sv
`timescale 1ns/1ps

module window_buffer #(
  parameter int IMG_COLS = 16,
  parameter int IMG_ROWS = 12,
  parameter int WIN      = 3
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          shift_i,
  input  img_pkg::pixel_t [WIN-1:0]     col_i,
  output logic                          win_valid_o,
  output img_pkg::pixel_t [WIN*WIN-1:0] win_o
);

  import img_pkg::*;

  localparam int COL_W = $clog2(IMG_COLS);
  localparam int ROW_W = $clog2(IMG_ROWS);

  pixel_t [WIN-1:0][WIN-1:0] win_q;  // column 0 holds the newest column.
  logic [COL_W-1:0] col_q;
  logic [ROW_W-1:0] row_q;
  logic             win_valid_q;
  logic             col_last;
  logic             row_last;

  assign col_last = (col_q == COL_W'(IMG_COLS - 1));
  assign row_last = (row_q == ROW_W'(IMG_ROWS - 1));

  always_ff @(posedge clk) begin
    if (shift_i) begin
      win_q <= {win_q[WIN-2:0], col_i};
    end
  end

  // counters track the position of the pixel that is being shifted in.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_q       <= '0;
      row_q       <= '0;
      win_valid_q <= 1'b0;
    end else begin
      win_valid_q <= shift_i && (col_q >= WIN - 1) && (row_q >= WIN - 1);
      if (shift_i) begin
        if (col_last) begin
          col_q <= '0;
          if (row_last) begin
            row_q <= '0;  // end of frame.
          end else begin
            row_q <= row_q + 1'b1;
          end
        end else begin
          col_q <= col_q + 1'b1;
        end
      end
    end
  end

  assign win_valid_o = win_valid_q;
  assign win_o       = win_q;

endmodule

//--- verif/dilate_sva.sv
`timescale 1ns/1ps

module dilate_sva (
  input logic clk,
  input logic rst_n,
  input logic start_i,
  input logic done_i,
  input logic wr_req_i,
  input logic wr_gnt_i,
  input logic rd_gnt_i,
  input logic rd_valid_i,
  input logic host_gnt_i,
  input logic host_we_i,
  input logic host_rvalid_i
);

  int unsigned fail_cnt = 0;

  gnt_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({wr_gnt_i, rd_gnt_i, host_gnt_i}))
    else begin
      $error("more than one memory grant in one cycle");
      fail_cnt++;
    end

  wr_gnt_a: assert property (@(posedge clk) disable iff (!rst_n) wr_req_i |-> wr_gnt_i)
    else begin
      $error("writer request was not granted in the same cycle");
      fail_cnt++;
    end

  rd_valid_a: assert property (@(posedge clk) disable iff (!rst_n)
    rd_valid_i |-> $past(rd_gnt_i))
    else begin
      $error("reader data strobe without a granted read");
      fail_cnt++;
    end

  host_rvalid_a: assert property (@(posedge clk) disable iff (!rst_n)
    host_rvalid_i |-> $past(host_gnt_i && !host_we_i))
    else begin
      $error("host data strobe without a granted host read");
      fail_cnt++;
    end

  done_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    (done_i && !start_i) |=> done_i)
    else begin
      $error("done fell without a start");
      fail_cnt++;
    end

endmodule

bind dilate_top dilate_sva sva_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .start_i      (start_i),
  .done_i       (done_o),
  .wr_req_i     (wr_req),
  .wr_gnt_i     (wr_gnt),
  .rd_gnt_i     (rd_gnt),
  .rd_valid_i   (rd_valid),
  .host_gnt_i   (host_gnt_o),
  .host_we_i    (host_we_i),
  .host_rvalid_i(host_rvalid_o)
);

//--- verif/dilate_tb.sv
`timescale 1ns/1ps

module dilate_tb;

  import img_pkg::*;
  import mem_pkg::*;

  localparam int IMG_COLS = 16;
  localparam int IMG_ROWS = 12;
  localparam int WIN      = 3;
  localparam int NPIX     = IMG_COLS * IMG_ROWS;
  localparam int OUT_COLS = IMG_COLS - WIN + 1;
  localparam int OUT_ROWS = IMG_ROWS - WIN + 1;
  localparam int NRES     = OUT_COLS * OUT_ROWS;
  localparam int TIMEOUT  = 4000;  // cycles allowed for any single wait.

  logic        clk;
  logic        rst_n;
  logic        start;
  logic        done;
  logic        host_req;
  logic        host_we;
  addr_t       host_addr;
  word_t       host_wdata;
  logic        host_gnt;
  logic        host_rvalid;
  word_t       host_rdata;

  pixel_t      src [NPIX];
  pixel_t      expd [NRES];
  logic [31:0] lfsr_q;
  string       test_name;
  int          err_cnt;
  int          check_cnt;
  int          test_cnt;
  int          test_err0;

  dilate_top #(
    .IMG_COLS(IMG_COLS),
    .IMG_ROWS(IMG_ROWS),
    .WIN     (WIN)
  ) dilate_top_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start),
    .done_o       (done),
    .host_req_i   (host_req),
    .host_we_i    (host_we),
    .host_addr_i  (host_addr),
    .host_wdata_i (host_wdata),
    .host_gnt_o   (host_gnt),
    .host_rvalid_o(host_rvalid),
    .host_rdata_o (host_rdata)
  );

  always #2 clk = ~clk;

  // taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic pixel_t rand_byte();
    pixel_t b;
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      b      = {b[6:0], lfsr_q[0]};
    end
    return b;
  endfunction

  // each result is the largest source pixel under its window.
  function automatic void ref_model();
    pixel_t m;
    pixel_t p;
    for (int r = 0; r < OUT_ROWS; r++) begin
      for (int c = 0; c < OUT_COLS; c++) begin
        m = '0;
        for (int dr = 0; dr < WIN; dr++) begin
          for (int dc = 0; dc < WIN; dc++) begin
            p = src[(r + dr) * IMG_COLS + c + dc];
            if (p > m) begin
              m = p;
            end
          end
        end
        expd[r * OUT_COLS + c] = m;
      end
    end
  endfunction

  // looks half a phase after the falling edge, when the grant is settled.
  task automatic wait_host_grant(output bit ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < TIMEOUT) begin
      #1;
      if (host_gnt) begin
        ok = 1'b1;
      end else begin
        @(negedge clk);
        n++;
      end
    end
  endtask

  task automatic host_write(input addr_t addr, input word_t data);
    bit ok;
    @(negedge clk);
    host_req   = 1'b1;
    host_we    = 1'b1;
    host_addr  = addr;
    host_wdata = data;
    wait_host_grant(ok);
    if (!ok) begin
      $display("%s: host write to address %0d was never granted", test_name, addr);
      err_cnt++;
    end
    @(negedge clk);
    host_req = 1'b0;
    host_we  = 1'b0;
  endtask

  task automatic host_read(input addr_t addr, output word_t data);
    bit ok;
    int n;
    data = '0;
    @(negedge clk);
    host_req  = 1'b1;
    host_we   = 1'b0;
    host_addr = addr;
    wait_host_grant(ok);
    @(negedge clk);
    host_req = 1'b0;
    n = 0;
    while (ok && !host_rvalid && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!ok || !host_rvalid) begin
      $display("%s: host read of address %0d returned no data", test_name, addr);
      err_cnt++;
    end else begin
      data = host_rdata;
    end
  endtask

  task automatic load_frame();
    for (int i = 0; i < NPIX; i++) begin
      host_write(addr_t'(i), src[i]);
    end
  endtask

  task automatic run_frame();
    int n;
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    check_cnt++;
    if (done) begin
      $display("%s: done_o stayed high after start", test_name);
      err_cnt++;
    end
    n = 0;
    while (!done && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!done) begin
      $display("%s: timeout waiting for done_o", test_name);
      err_cnt++;
    end
  endtask

  task automatic check_results();
    word_t got;
    for (int i = 0; i < NRES; i++) begin
      host_read(addr_t'(RES_BASE + i), got);
      check_cnt++;
      if (got !== expd[i]) begin
        $display("error %s: result %0d expected %h actual %h", test_name, i, expd[i], got);
        err_cnt++;
      end
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err0 = err_cnt;
  endtask

  task automatic finish_test();
    test_cnt++;
    if (err_cnt == test_err0) begin
      $display("test %s: pass", test_name);
    end else begin
      $display("test %s: %0d failing checks", test_name, err_cnt - test_err0);
    end
  endtask

  task automatic test_reset_state();
    word_t got;
    start_test("reset_state");
    check_cnt++;
    if (done !== 1'b0) begin
      $display("error %s: done_o expected 0 actual %b", test_name, done);
      err_cnt++;
    end
    check_cnt++;
    if (host_gnt !== 1'b0) begin
      $display("error %s: host_gnt_o expected 0 actual %b", test_name, host_gnt);
      err_cnt++;
    end
    host_write(addr_t'(RES_BASE + 200), 8'h3c);
    host_read(addr_t'(RES_BASE + 200), got);
    check_cnt++;
    if (got !== 8'h3c) begin
      $display("error %s: read back expected 3c actual %h", test_name, got);
      err_cnt++;
    end
    finish_test();
  endtask

  task automatic test_constant();
    start_test("constant");
    for (int i = 0; i < NPIX; i++) begin
      src[i] = 8'h5a;
    end
    for (int i = 0; i < NRES; i++) begin
      expd[i] = 8'h5a;
    end
    load_frame();
    run_frame();
    check_results();
    finish_test();
  endtask

  task automatic test_bright_pixel();
    int br_row;
    int br_col;
    br_row = 5;
    br_col = 7;
    start_test("bright_pixel");
    for (int i = 0; i < NPIX; i++) begin
      src[i] = '0;
    end
    src[br_row * IMG_COLS + br_col] = 8'hc8;
    for (int r = 0; r < OUT_ROWS; r++) begin
      for (int c = 0; c < OUT_COLS; c++) begin
        if (r <= br_row && br_row < r + WIN && c <= br_col && br_col < c + WIN) begin
          expd[r * OUT_COLS + c] = 8'hc8;
        end else begin
          expd[r * OUT_COLS + c] = '0;
        end
      end
    end
    load_frame();
    run_frame();
    check_results();
    finish_test();
  endtask

  task automatic random_frame_test(input string name);
    start_test(name);
    for (int i = 0; i < NPIX; i++) begin
      src[i] = rand_byte();
    end
    ref_model();
    load_frame();
    run_frame();
    check_results();
    finish_test();
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    start      = 1'b0;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    lfsr_q     = 32'h0d526b88;
    err_cnt    = 0;
    check_cnt  = 0;
    test_cnt   = 0;
    test_name  = "setup";
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    test_reset_state();
    test_constant();
    test_bright_pixel();
    random_frame_test("lfsr_frame");
    check_cnt++;
    if (!done) begin
      $display("restart: done_o was not high before the second frame");
      err_cnt++;
    end
    random_frame_test("restart");

    err_cnt += dilate_top_i.sva_i.fail_cnt;
    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
